//--- wbuf_pkg.sv
/*
 * Coalescing write buffer shared definitions.
 * Sizes, entry states and the packed write, line, entry and memory types.
 */
package wbuf_pkg;

    localparam int WBUF_ENTRIES      = 4;
    localparam int WBUF_ADDR_WIDTH   = 32;
    localparam int WBUF_WORD_WIDTH   = 64;
    localparam int WBUF_BE_WIDTH     = WBUF_WORD_WIDTH / 8;
    localparam int WBUF_WORDS        = 2;
    localparam int WBUF_WORD_OFFSET  = $clog2(WBUF_BE_WIDTH);
    localparam int WBUF_OFFSET_WIDTH = $clog2(WBUF_BE_WIDTH * WBUF_WORDS);
    localparam int WBUF_TAG_WIDTH    = WBUF_ADDR_WIDTH - WBUF_OFFSET_WIDTH;
    localparam int WBUF_CNT_WIDTH    = 4;
    localparam int WBUF_ID_WIDTH     = $clog2(WBUF_ENTRIES);

    // Send queue holds one id per entry
    localparam int WBUF_QUEUE_DEPTH  = WBUF_ENTRIES;
    localparam int WBUF_QCNT_WIDTH   = $clog2(WBUF_QUEUE_DEPTH + 1);

    typedef logic [WBUF_ID_WIDTH-1:0]  wbuf_id_t;
    typedef logic [WBUF_TAG_WIDTH-1:0] wbuf_tag_t;
    typedef logic [WBUF_CNT_WIDTH-1:0] wbuf_cnt_t;

    typedef enum logic [1:0] {
        FREE = 2'b00,
        OPEN = 2'b01,
        PEND = 2'b10,
        SENT = 2'b11
    } wbuf_state_e;

    typedef struct packed {
        logic [WBUF_ADDR_WIDTH-1:0] addr;
        logic [WBUF_WORD_WIDTH-1:0] data;
        logic [WBUF_BE_WIDTH-1:0]   be;
    } wbuf_write_t;

    typedef struct packed {
        logic [WBUF_WORDS-1:0][WBUF_WORD_WIDTH-1:0] data;
        logic [WBUF_WORDS-1:0][WBUF_BE_WIDTH-1:0]   be;
    } wbuf_line_t;

    typedef struct packed {
        wbuf_tag_t  tag;
        wbuf_cnt_t  cnt;
        wbuf_line_t line;
    } wbuf_entry_t;

    typedef struct packed {
        logic [WBUF_ADDR_WIDTH-1:0] addr;
        wbuf_id_t                   id;
        wbuf_line_t                 line;
    } wbuf_mem_req_t;

    typedef struct packed {
        wbuf_id_t id;
    } wbuf_mem_resp_t;

    // First requesting index at or after ptr, wrapping around
    function automatic wbuf_id_t wbuf_rr_pick(input logic [WBUF_ENTRIES-1:0] req,
                                              input wbuf_id_t ptr);
        wbuf_id_t idx;
        wbuf_id_t pick;
        pick = ptr;
        for (int k = WBUF_ENTRIES - 1; k >= 0; k--) begin
            idx = ptr + wbuf_id_t'(k);
            if (req[idx]) begin
                pick = idx;
            end
        end
        return pick;
    endfunction

endpackage

//--- wbuf_write_ctrl.sv
/*
 * Write buffer input side.
 * Matches incoming writes against open and pending lines, else picks a free entry.
 */
`timescale 1ns/1ps

module wbuf_write_ctrl
    import wbuf_pkg::*;
(
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           write_valid_i,
    input  wbuf_write_t                    write_i,
    input  wbuf_entry_t [WBUF_ENTRIES-1:0] entries_i,
    input  wbuf_state_e [WBUF_ENTRIES-1:0] states_i,
    output logic                           write_ready_o,
    output logic                           alloc_o,
    output logic                           hit_o,
    output wbuf_id_t                       target_id_o
);

    wbuf_tag_t               write_tag;
    logic [WBUF_ENTRIES-1:0] hit_bv;
    logic [WBUF_ENTRIES-1:0] free_bv;
    wbuf_id_t                hit_id;
    wbuf_id_t                free_id;
    wbuf_id_t                alloc_ptr_q;
    logic                    hit;
    logic                    any_free;
    logic                    accept;

    assign write_tag = write_i.addr[WBUF_ADDR_WIDTH-1:WBUF_OFFSET_WIDTH];

    // SENT lines are never merged into, a new entry is taken instead
    always_comb begin
        for (int i = 0; i < WBUF_ENTRIES; i++) begin
            free_bv[i] = (states_i[i] == FREE);
            hit_bv[i]  = ((states_i[i] == OPEN) || (states_i[i] == PEND)) &&
                         (entries_i[i].tag == write_tag);
        end
    end

    // At most one live entry per line
    always_comb begin
        hit_id = '0;
        for (int i = 0; i < WBUF_ENTRIES; i++) begin
            if (hit_bv[i]) begin
                hit_id = wbuf_id_t'(i);
            end
        end
    end

    assign hit      = |hit_bv;
    assign any_free = |free_bv;
    assign free_id  = wbuf_rr_pick(free_bv, alloc_ptr_q);

    assign write_ready_o = hit | any_free;
    assign accept        = write_valid_i & write_ready_o;
    assign hit_o         = accept & hit;
    assign alloc_o       = accept & ~hit;
    assign target_id_o   = hit ? hit_id : free_id;

    // Rotate past the entry just taken
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            alloc_ptr_q <= '0;
        end else if (alloc_o) begin
            alloc_ptr_q <= free_id + 1'b1;
        end
    end

endmodule

//--- wbuf_dir.sv
/*
 * Write buffer directory.
 * Holds entry state, tag, timer and merged line, and runs the entry life cycle.
 */
`timescale 1ns/1ps

module wbuf_dir
    import wbuf_pkg::*;
(
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  wbuf_write_t                    write_i,
    input  logic                           alloc_i,
    input  logic                           hit_i,
    input  wbuf_id_t                       target_id_i,
    input  wbuf_cnt_t                      cfg_threshold_i,
    input  logic                           flush_i,
    input  logic                           grant_i,
    input  wbuf_id_t                       grant_id_i,
    input  logic                           mem_resp_valid_i,
    input  wbuf_mem_resp_t                 mem_resp_i,
    output wbuf_entry_t [WBUF_ENTRIES-1:0] entries_o,
    output wbuf_state_e [WBUF_ENTRIES-1:0] states_o,
    output logic                           empty_o,
    output logic                           full_o
);

    wbuf_state_e [WBUF_ENTRIES-1:0] state_q;
    wbuf_state_e [WBUF_ENTRIES-1:0] state_d;
    wbuf_entry_t [WBUF_ENTRIES-1:0] entries_q;
    wbuf_entry_t [WBUF_ENTRIES-1:0] entries_d;
    wbuf_line_t                     write_line;
    logic [WBUF_ENTRIES-1:0]        free_bv;

    // New bytes win where their enable is set, enables accumulate
    function automatic wbuf_line_t merge_line(input wbuf_line_t old_line,
                                              input wbuf_line_t new_line);
        wbuf_line_t res;
        for (int w = 0; w < WBUF_WORDS; w++) begin
            for (int b = 0; b < WBUF_BE_WIDTH; b++) begin
                res.data[w][b*8 +: 8] = new_line.be[w][b] ? new_line.data[w][b*8 +: 8] :
                                                            old_line.data[w][b*8 +: 8];
            end
        end
        res.be = old_line.be | new_line.be;
        return res;
    endfunction

    // Word placed in every slot, only the addressed slot gets enables
    always_comb begin
        write_line.data = {WBUF_WORDS{write_i.data}};
        write_line.be   = '0;
        write_line.be[write_i.addr[WBUF_OFFSET_WIDTH-1:WBUF_WORD_OFFSET]] = write_i.be;
    end

    always_comb begin
        logic [WBUF_CNT_WIDTH:0] cnt_inc;
        logic                    sel;
        state_d   = state_q;
        entries_d = entries_q;
        for (int i = 0; i < WBUF_ENTRIES; i++) begin
            sel     = (target_id_i == wbuf_id_t'(i));
            cnt_inc = {1'b0, entries_q[i].cnt} + 1'b1;
            unique case (state_q[i])
                FREE: begin
                    if (alloc_i && sel) begin
                        state_d[i]        = (flush_i || (cfg_threshold_i == '0)) ? PEND : OPEN;
                        entries_d[i].tag  = write_i.addr[WBUF_ADDR_WIDTH-1:WBUF_OFFSET_WIDTH];
                        entries_d[i].cnt  = '0;
                        entries_d[i].line = merge_line('0, write_line);
                    end
                end
                OPEN: begin
                    if (hit_i && sel) begin
                        entries_d[i].line = merge_line(entries_q[i].line, write_line);
                    end
                    // Timeout also covers a threshold lowered below the count
                    if (flush_i || (cnt_inc >= {1'b0, cfg_threshold_i})) begin
                        state_d[i] = PEND;
                    end else begin
                        entries_d[i].cnt = entries_q[i].cnt + 1'b1;
                    end
                end
                PEND: begin
                    if (hit_i && sel) begin
                        entries_d[i].line = merge_line(entries_q[i].line, write_line);
                    end
                    if (grant_i && (grant_id_i == wbuf_id_t'(i))) begin
                        state_d[i] = SENT;
                    end
                end
                SENT: begin
                    if (mem_resp_valid_i && (mem_resp_i.id == wbuf_id_t'(i))) begin
                        state_d[i] = FREE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < WBUF_ENTRIES; i++) begin
                state_q[i] <= FREE;
            end
        end else begin
            state_q <= state_d;
        end
    end

    // Entry contents only matter while the state is not FREE
    always_ff @(posedge clk_i) begin
        entries_q <= entries_d;
    end

    always_comb begin
        for (int i = 0; i < WBUF_ENTRIES; i++) begin
            free_bv[i] = (state_q[i] == FREE);
        end
    end

    assign empty_o   = &free_bv;
    assign full_o    = ~|free_bv;
    assign entries_o = entries_q;
    assign states_o  = state_q;

endmodule

//--- wbuf_send.sv
/*
 * Write buffer output side.
 * Round-robin grant of pending entries into an id FIFO that feeds the memory request.
 */
`timescale 1ns/1ps

module wbuf_send
    import wbuf_pkg::*;
(
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  wbuf_entry_t [WBUF_ENTRIES-1:0] entries_i,
    input  wbuf_state_e [WBUF_ENTRIES-1:0] states_i,
    output logic                           grant_o,
    output wbuf_id_t                       grant_id_o,
    input  logic                           mem_req_ready_i,
    output logic                           mem_req_valid_o,
    output wbuf_mem_req_t                  mem_req_o
);

    logic [WBUF_ENTRIES-1:0]         pend_bv;
    wbuf_id_t                        rr_ptr_q;
    wbuf_id_t [WBUF_QUEUE_DEPTH-1:0] queue_q;
    wbuf_id_t                        wr_ptr_q;
    wbuf_id_t                        rd_ptr_q;
    logic [WBUF_QCNT_WIDTH-1:0]      count_q;
    wbuf_id_t                        head_id;
    logic                            queue_full;
    logic                            push;
    logic                            pop;

    always_comb begin
        for (int i = 0; i < WBUF_ENTRIES; i++) begin
            pend_bv[i] = (states_i[i] == PEND);
        end
    end

    assign queue_full = (count_q == WBUF_QCNT_WIDTH'(WBUF_QUEUE_DEPTH));
    assign grant_o    = (|pend_bv) & ~queue_full;
    assign grant_id_o = wbuf_rr_pick(pend_bv, rr_ptr_q);

    assign push = grant_o;
    assign pop  = mem_req_valid_o & mem_req_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_ptr_q <= '0;
        end else if (grant_o) begin
            rr_ptr_q <= grant_id_o + 1'b1;
        end
    end

    // Id FIFO storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            queue_q[wr_ptr_q] <= grant_id_o;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Head entry is SENT, so its line holds still under back-pressure
    assign head_id         = queue_q[rd_ptr_q];
    assign mem_req_valid_o = (count_q != '0);
    assign mem_req_o.addr  = {entries_i[head_id].tag, {WBUF_OFFSET_WIDTH{1'b0}}};
    assign mem_req_o.id    = head_id;
    assign mem_req_o.line  = entries_i[head_id].line;

endmodule

//--- wbuf_top.sv
/*
 * Coalescing write buffer top level.
 * Joins write control, entry directory and send side.
 */
`timescale 1ns/1ps

module wbuf_top
    import wbuf_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           write_valid_i,
    input  wbuf_write_t    write_i,
    output logic           write_ready_o,
    output logic           mem_req_valid_o,
    output wbuf_mem_req_t  mem_req_o,
    input  logic           mem_req_ready_i,
    input  logic           mem_resp_valid_i,
    input  wbuf_mem_resp_t mem_resp_i,
    input  wbuf_cnt_t      cfg_threshold_i,
    input  logic           flush_i,
    output logic           empty_o,
    output logic           full_o
);

    wbuf_entry_t [WBUF_ENTRIES-1:0] entries;
    wbuf_state_e [WBUF_ENTRIES-1:0] states;
    logic                           alloc;
    logic                           hit;
    wbuf_id_t                       target_id;
    logic                           grant;
    wbuf_id_t                       grant_id;

    wbuf_write_ctrl u_write_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .write_valid_i (write_valid_i),
        .write_i       (write_i),
        .entries_i     (entries),
        .states_i      (states),
        .write_ready_o (write_ready_o),
        .alloc_o       (alloc),
        .hit_o         (hit),
        .target_id_o   (target_id)
    );

    wbuf_dir u_dir (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .write_i          (write_i),
        .alloc_i          (alloc),
        .hit_i            (hit),
        .target_id_i      (target_id),
        .cfg_threshold_i  (cfg_threshold_i),
        .flush_i          (flush_i),
        .grant_i          (grant),
        .grant_id_i       (grant_id),
        .mem_resp_valid_i (mem_resp_valid_i),
        .mem_resp_i       (mem_resp_i),
        .entries_o        (entries),
        .states_o         (states),
        .empty_o          (empty_o),
        .full_o           (full_o)
    );

    wbuf_send u_send (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .entries_i       (entries),
        .states_i        (states),
        .grant_o         (grant),
        .grant_id_o      (grant_id),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o)
    );

endmodule

//--- wbuf_checker.sv
/*
 * Write buffer protocol checker.
 * Request stability, status consistency and response id tracking.
 */
`timescale 1ns/1ps

module wbuf_checker
    import wbuf_pkg::*;
(
    input logic           clk_i,
    input logic           rst_ni,
    input logic           mem_req_valid_o,
    input logic           mem_req_ready_i,
    input wbuf_mem_req_t  mem_req_o,
    input logic           mem_resp_valid_i,
    input wbuf_mem_resp_t mem_resp_i,
    input logic           empty_o,
    input logic           full_o
);

    // Ids with a request accepted and no response yet
    logic [WBUF_ENTRIES-1:0] outstanding_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            outstanding_q <= '0;
        end else begin
            if (mem_resp_valid_i) begin
                outstanding_q[mem_resp_i.id] <= 1'b0;
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                outstanding_q[mem_req_o.id] <= 1'b1;
            end
        end
    end

    req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_valid_o && !mem_req_ready_i) |=> (mem_req_valid_o && $stable(mem_req_o)))
        else $error("request dropped or changed under back-pressure");

    // An empty buffer has nothing queued for memory
    empty_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        empty_o |-> (!full_o && !mem_req_valid_o))
        else $error("empty buffer reports full or still requests memory");

    resp_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_resp_valid_i |-> outstanding_q[mem_resp_i.id])
        else $error("response for an id with no request outstanding");

endmodule

bind wbuf_top wbuf_checker u_checker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_req_o        (mem_req_o),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_i       (mem_resp_i),
    .empty_o          (empty_o),
    .full_o           (full_o)
);

//--- tb_wbuf.sv
/*
 * Testbench for the coalescing write buffer.
 * Applies a table of writes and checks every memory request against the table.
 */
`timescale 1ns/1ps

module tb_wbuf
    import wbuf_pkg::*;
();

    typedef struct packed {
        logic [31:0]  addr;
        logic [63:0]  data;
        logic [7:0]   be;
        logic [3:0]   thr;
        logic         flush;
        logic         exp;
        logic [31:0]  exp_addr;
        logic [127:0] exp_data;
        logic [15:0]  exp_be;
        logic         wait_empty;
        logic         chk_lat;
        logic         chk_full;
    } row_t;

    localparam int ROWS        = 13;
    localparam int WATCHDOG_NS = (ROWS * 60 + 100) * 20;

    logic           clk_i;
    logic           rst_ni;
    logic           write_valid_i;
    wbuf_write_t    write_i;
    logic           write_ready_o;
    logic           mem_req_valid_o;
    wbuf_mem_req_t  mem_req_o;
    logic           mem_req_ready_i;
    logic           mem_resp_valid_i;
    wbuf_mem_resp_t mem_resp_i;
    wbuf_cnt_t      cfg_threshold_i;
    logic           flush_i;
    logic           empty_o;
    logic           full_o;

    row_t        tbl [ROWS];
    row_t        exp_q [$];
    wbuf_id_t    resp_id_q [$];
    int          resp_due_q [$];
    logic [31:0] lfsr;
    int          cycle;

    wbuf_top u_wbuf_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic die();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_hex(input string name, input logic [127:0] got, input logic [127:0] ev);
        assert (got === ev) else begin
            $display("FAIL %s got %h exp %h", name, got, ev);
            die();
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("%s", msg);
            die();
        end
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [3:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[2:0], lfsr[0]};
        end
    endtask

    function automatic logic [127:0] be_mask(input logic [15:0] be);
        logic [127:0] m;
        for (int b = 0; b < 16; b++) begin
            m[b*8 +: 8] = {8{be[b]}};
        end
        return m;
    endfunction

    // Memory model: checks each accepted request, answers after a random delay
    initial begin
        logic [3:0] d;
        int         idx;
        forever begin
            @(negedge clk_i);
            if (rst_ni && mem_req_valid_o && mem_req_ready_i) begin
                idx = -1;
                foreach (exp_q[k]) begin
                    if (idx < 0 && exp_q[k].exp_addr == mem_req_o.addr) begin
                        idx = k;
                    end
                end
                check_true(idx >= 0, "Memory request for a line that was not expected");
                check_hex("mem_req_o.line.be", 128'(mem_req_o.line.be), 128'(exp_q[idx].exp_be));
                check_hex("mem_req_o.line.data", mem_req_o.line.data & be_mask(exp_q[idx].exp_be),
                          exp_q[idx].exp_data);
                exp_q.delete(idx);
                rand_bits(2, d);
                resp_id_q.push_back(mem_req_o.id);
                resp_due_q.push_back(cycle + 1 + int'(d));
            end
            @(posedge clk_i);
            #1;
            cycle++;
            rand_bits(1, d);
            mem_req_ready_i  = d[0];
            mem_resp_valid_i = 1'b0;
            if (resp_due_q.size() != 0 && resp_due_q[0] <= cycle) begin
                mem_resp_valid_i = 1'b1;
                mem_resp_i.id    = resp_id_q.pop_front();
                void'(resp_due_q.pop_front());
            end
        end
    end

    task automatic apply_row(input row_t r);
        int lat;
        @(posedge clk_i);
        #1;
        write_valid_i   = 1'b1;
        write_i.addr    = r.addr;
        write_i.data    = r.data;
        write_i.be      = r.be;
        cfg_threshold_i = r.thr;
        flush_i         = r.flush;
        if (r.exp) begin
            exp_q.push_back(r);
        end
        @(negedge clk_i);
        while (!write_ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        write_valid_i = 1'b0;
        flush_i       = 1'b0;
        if (r.chk_lat) begin
            lat = 1;
            @(negedge clk_i);
            while (!mem_req_valid_o) begin
                lat++;
                @(negedge clk_i);
            end
            check_true(lat > int'(r.thr), "Request left before the timeout expired");
        end
        if (r.chk_full) begin
            @(negedge clk_i);
            check_hex("full_o", 128'(full_o), 128'(1));
            @(posedge clk_i);
            #1;
            write_i.addr = 32'h0000_F000;
            @(negedge clk_i);
            check_hex("write_ready_o", 128'(write_ready_o), 128'(0));
            @(posedge clk_i);
            #1;
            write_i.addr = r.addr;
            @(negedge clk_i);
            check_hex("write_ready_o", 128'(write_ready_o), 128'(1));
        end
        if (r.wait_empty) begin
            @(negedge clk_i);
            while (!empty_o) begin
                @(negedge clk_i);
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out waiting for the write buffer");
        die();
    end

    initial begin
        lfsr             = 32'h885f;
        cycle            = 0;
        rst_ni           = 1'b0;
        write_valid_i    = 1'b0;
        write_i          = '0;
        mem_req_ready_i  = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_i       = '0;
        cfg_threshold_i  = '0;
        flush_i          = 1'b0;

        // addr, data, be, thr, flush, exp, exp addr, exp data, exp be, wait, lat, full
        tbl[0]  = '{32'h1008, 64'h1122_3344_5566_7788, 8'hFF, 4'd0, 1'b0, 1'b1, 32'h1000,
                    {64'h1122_3344_5566_7788, 64'h0}, 16'hFF00, 1'b1, 1'b0, 1'b0};
        // Coalescing, later bytes win
        tbl[1]  = '{32'h2000, 64'hA0A1_A2A3_A4A5_A6A7, 8'h0F, 4'd15, 1'b0, 1'b0, 32'h0,
                    128'h0, 16'h0, 1'b0, 1'b0, 1'b0};
        tbl[2]  = '{32'h2000, 64'hB0B1_B2B3_B4B5_B6B7, 8'h3C, 4'd15, 1'b0, 1'b0, 32'h0,
                    128'h0, 16'h0, 1'b0, 1'b0, 1'b0};
        tbl[3]  = '{32'h2008, 64'hC0C1_C2C3_C4C5_C6C7, 8'h81, 4'd15, 1'b1, 1'b1, 32'h2000,
                    {64'hC000_0000_0000_00C7, 64'h0000_B2B3_B4B5_A6A7}, 16'h813F,
                    1'b1, 1'b0, 1'b0};
        tbl[4]  = '{32'h3000, 64'h0123_4567_89AB_CDEF, 8'hFF, 4'd6, 1'b0, 1'b1, 32'h3000,
                    {64'h0, 64'h0123_4567_89AB_CDEF}, 16'h00FF, 1'b1, 1'b1, 1'b0};
        // Four lines fill the buffer
        tbl[5]  = '{32'h4000, 64'h11, 8'h01, 4'd15, 1'b0, 1'b1, 32'h4000,
                    128'h11, 16'h0001, 1'b0, 1'b0, 1'b0};
        tbl[6]  = '{32'h5008, 64'h2200_0000_0000_0000, 8'h80, 4'd15, 1'b0, 1'b1, 32'h5000,
                    {64'h2200_0000_0000_0000, 64'h0}, 16'h8000, 1'b0, 1'b0, 1'b0};
        tbl[7]  = '{32'h6000, 64'h33, 8'h01, 4'd15, 1'b0, 1'b1, 32'h6000,
                    128'h33, 16'h0001, 1'b0, 1'b0, 1'b0};
        tbl[8]  = '{32'h7000, 64'h44, 8'h01, 4'd15, 1'b0, 1'b0, 32'h0,
                    128'h0, 16'h0, 1'b0, 1'b0, 1'b1};
        tbl[9]  = '{32'h7000, 64'h5500, 8'h02, 4'd15, 1'b1, 1'b1, 32'h7000,
                    128'h5544, 16'h0003, 1'b1, 1'b0, 1'b0};
        // Back to back lines under random back-pressure
        tbl[10] = '{32'h8000, 64'hDEAD_BEEF_0000_0001, 8'hFF, 4'd0, 1'b0, 1'b1, 32'h8000,
                    {64'h0, 64'hDEAD_BEEF_0000_0001}, 16'h00FF, 1'b0, 1'b0, 1'b0};
        tbl[11] = '{32'h9008, 64'hCAFE_F00D_1234_5678, 8'hF0, 4'd0, 1'b0, 1'b1, 32'h9000,
                    {64'hCAFE_F00D_0000_0000, 64'h0}, 16'hF000, 1'b0, 1'b0, 1'b0};
        tbl[12] = '{32'hA000, 64'h0102_0304_0506_0708, 8'h18, 4'd0, 1'b0, 1'b1, 32'hA000,
                    {64'h0, 64'h0000_0004_0500_0000}, 16'h0018, 1'b1, 1'b0, 1'b0};

        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_hex("empty_o", 128'(empty_o), 128'(1));
        check_hex("full_o", 128'(full_o), 128'(0));
        check_hex("write_ready_o", 128'(write_ready_o), 128'(1));
        check_hex("mem_req_valid_o", 128'(mem_req_valid_o), 128'(0));

        for (int r = 0; r < ROWS; r++) begin
            apply_row(tbl[r]);
        end
        check_true(exp_q.size() == 0, "Expected requests never reached memory");

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- flist.f
wbuf_pkg.sv
wbuf_write_ctrl.sv
wbuf_dir.sv
wbuf_send.sv
wbuf_top.sv
wbuf_checker.sv
tb_wbuf.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_wbuf -f flist.f -o sim_wbuf

out=$(./obj_dir/sim_wbuf || true)
echo "$out"

if echo "$out" | grep -q 'All tests passed!'; then
    exit 0
else
    exit 1
fi
